/* htu_geom_pkg.sv */
package htu_geom_pkg;

  // --------------------
  // address layout
  // --------------------
  localparam int ADDR_W     = 32;
  localparam int LINE_LSB   = 5;
  // selects the 16-byte half of a line
  localparam int OFFSET_BIT = 4;
  localparam int TAG_LSB    = 8;
  localparam int TAG_W      = ADDR_W - TAG_LSB;

  // --------------------
  // array size
  // --------------------
  localparam int NUM_SETS = 8;
  localparam int NUM_WAYS = 8;
  localparam int SET_W    = 3;
  localparam int WAY_W    = 3;

  // request side ids
  localparam int CH_W   = 2;
  localparam int WBUF_W = 8;

  typedef logic [SET_W-1:0]             set_idx_t;
  typedef logic [WAY_W-1:0]             way_idx_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [ADDR_W-1:LINE_LSB]     line_addr_t;
  // crossbar address, line address plus the half select bit
  typedef logic [ADDR_W-1:OFFSET_BIT]   req_addr_t;

endpackage

/* htu_op_pkg.sv */
package htu_op_pkg;

  // --------------------
  // crossbar opcodes
  // --------------------
  typedef enum logic [1:0] {
    OP_READ       = 2'd0,
    OP_WRITE      = 2'd1,
    // old flush encoding, never hits and changes nothing
    OP_RSVD       = 2'd2,
    OP_INVALIDATE = 2'd3
  } xbar_op_e;

  // --------------------
  // issue unit opcodes
  // --------------------
  // bit 0 write, bit 1 evict
  typedef enum logic [1:0] {
    ISU_READ        = 2'd0,
    ISU_WRITE       = 2'd1,
    ISU_READ_EVICT  = 2'd2,
    ISU_WRITE_EVICT = 2'd3
  } isu_op_e;

  // per half-line state
  typedef enum logic [1:0] {
    HS_EMPTY = 2'd0,
    HS_CLEAN = 2'd1,
    HS_DIRTY = 2'd3
  } half_state_e;

endpackage

/* htu_set_entry.sv */
`timescale 1ns/1ps

module htu_set_entry
  import htu_geom_pkg::*, htu_op_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        access_we_i,
  input  xbar_op_e    op_i,
  input  tag_t        tag_i,
  input  logic        offset_i,
  output logic        hit_o,
  output way_idx_t    way_o,
  output half_state_e half0_state_o,
  output half_state_e half1_state_o,
  output logic        evict_o
);

  tag_t                tag_q   [NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_q;
  half_state_e         half0_q [NUM_WAYS];
  half_state_e         half1_q [NUM_WAYS];
  way_idx_t            victim_q;

  logic [NUM_WAYS-1:0] hit_vec;
  way_idx_t            hit_way;
  logic                any_hit;
  logic                is_access;
  logic                line_dirty;
  half_state_e         sel_state;
  half_state_e         fill_state;

  // --------------------
  // lookup
  // --------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = valid_q[w] && (tag_q[w] == tag_i);
    end
  end

  // tags are unique within a set, so at most one bit is set
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign is_access = (op_i == OP_READ) || (op_i == OP_WRITE);
  assign any_hit   = (op_i != OP_RSVD) && (|hit_vec);

  assign hit_o         = any_hit;
  assign way_o         = any_hit ? hit_way : victim_q;
  assign half0_state_o = half0_q[way_o];
  assign half1_state_o = half1_q[way_o];

  assign sel_state  = offset_i ? half1_state_o : half0_state_o;
  assign line_dirty = (half0_state_o == HS_DIRTY) || (half1_state_o == HS_DIRTY);
  assign fill_state = (op_i == OP_WRITE) ? HS_DIRTY : HS_CLEAN;

  // dirty victim on an allocating miss, or a dirty line being invalidated
  assign evict_o = line_dirty
                 && ((is_access && !any_hit && valid_q[victim_q])
                     || (op_i == OP_INVALIDATE && any_hit));

  // --------------------
  // state update
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q  <= '0;
      victim_q <= '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        half0_q[w] <= HS_EMPTY;
        half1_q[w] <= HS_EMPTY;
      end
    end else if (access_we_i) begin
      if (any_hit) begin
        case (op_i)
          OP_READ: begin
            // fill of an empty half
            if (sel_state == HS_EMPTY) begin
              if (offset_i) begin
                half1_q[hit_way] <= HS_CLEAN;
              end else begin
                half0_q[hit_way] <= HS_CLEAN;
              end
            end
          end
          OP_WRITE: begin
            if (offset_i) begin
              half1_q[hit_way] <= HS_DIRTY;
            end else begin
              half0_q[hit_way] <= HS_DIRTY;
            end
          end
          OP_INVALIDATE: begin
            valid_q[hit_way] <= 1'b0;
            half0_q[hit_way] <= HS_EMPTY;
            half1_q[hit_way] <= HS_EMPTY;
          end
          default: begin
          end
        endcase
      end else if (is_access) begin
        // allocate the victim way
        valid_q[victim_q] <= 1'b1;
        half0_q[victim_q] <= offset_i ? HS_EMPTY : fill_state;
        half1_q[victim_q] <= offset_i ? fill_state : HS_EMPTY;
        victim_q          <= way_idx_t'(victim_q + 1'b1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_we_i && is_access && !any_hit) begin
      tag_q[victim_q] <= tag_i;
    end
  end

endmodule

/* htu_tag_array.sv */
`timescale 1ns/1ps

module htu_tag_array
  import htu_geom_pkg::*, htu_op_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        kickoff_i,
  input  xbar_op_e    op_i,
  input  req_addr_t   addr_i,
  output logic        hit_o,
  output logic        evict_o,
  output way_idx_t    way_o,
  output half_state_e half0_state_o,
  output half_state_e half1_state_o
);

  set_idx_t            set_idx;
  tag_t                tag;
  logic                offset;

  logic [NUM_SETS-1:0] set_we;
  logic [NUM_SETS-1:0] set_hit;
  logic [NUM_SETS-1:0] set_evict;
  way_idx_t            set_way   [NUM_SETS];
  half_state_e         set_half0 [NUM_SETS];
  half_state_e         set_half1 [NUM_SETS];

  // address split
  assign set_idx = addr_i[TAG_LSB-1:LINE_LSB];
  assign tag     = addr_i[ADDR_W-1:TAG_LSB];
  assign offset  = addr_i[OFFSET_BIT];

  // --------------------
  // one entry per set
  // --------------------
  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    assign set_we[s] = kickoff_i && (set_idx == set_idx_t'(s));

    htu_set_entry u_set_entry (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .access_we_i  (set_we[s]),
      .op_i         (op_i),
      .tag_i        (tag),
      .offset_i     (offset),
      .hit_o        (set_hit[s]),
      .way_o        (set_way[s]),
      .half0_state_o(set_half0[s]),
      .half1_state_o(set_half1[s]),
      .evict_o      (set_evict[s])
    );
  end

  // addressed set results
  assign hit_o         = set_hit[set_idx];
  assign evict_o       = set_evict[set_idx];
  assign way_o         = set_way[set_idx];
  assign half0_state_o = set_half0[set_idx];
  assign half1_state_o = set_half1[set_idx];

endmodule

/* htu_dispatch.sv */
`timescale 1ns/1ps

module htu_dispatch
  import htu_geom_pkg::*, htu_op_pkg::*;
(
  // crossbar
  input  logic              xbar_valid_i,
  output logic              xbar_allow_in_o,
  input  xbar_op_e          xbar_opcode_i,
  input  req_addr_t         xbar_addr_i,
  input  logic [CH_W-1:0]   xbar_ch_id_i,
  input  logic [WBUF_W-1:0] xbar_wbuf_id_i,
  // tag array
  input  logic              hit_i,
  input  logic              evict_i,
  input  way_idx_t          way_i,
  input  half_state_e       half0_state_i,
  input  half_state_e       half1_state_i,
  output logic              kickoff_o,
  // issue unit
  output logic              isu_valid_o,
  input  logic              isu_allow_in_i,
  output logic [CH_W-1:0]   isu_ch_id_o,
  output isu_op_e           isu_opcode_o,
  output set_idx_t          isu_set_o,
  output way_idx_t          isu_way_o,
  output logic              isu_offset_o,
  output logic [WBUF_W-1:0] isu_wbuf_id_o,
  output half_state_e       isu_half0_state_o,
  output half_state_e       isu_half1_state_o,
  output logic              linefill_valid_o,
  // bus read address
  output logic              bus_arvalid_o,
  input  logic              bus_arready_i,
  output line_addr_t        bus_araddr_o
);

  logic        is_read;
  logic        is_write;
  logic        offset;
  half_state_e addr_state;
  logic        need_refill;
  logic        issue_ok;

  // --------------------
  // decode
  // --------------------
  assign is_read  = (xbar_opcode_i == OP_READ);
  assign is_write = (xbar_opcode_i == OP_WRITE);
  assign offset   = xbar_addr_i[OFFSET_BIT];

  assign addr_state = offset ? half1_state_i : half0_state_i;

  // miss, or hit with the addressed half not yet filled
  assign need_refill = is_read && (!hit_i || (addr_state == HS_EMPTY));

  // a refill only proceeds together with its bus request
  assign issue_ok = !need_refill || bus_arready_i;

  // --------------------
  // handshakes
  // --------------------
  assign xbar_allow_in_o  = isu_allow_in_i && issue_ok;
  assign kickoff_o        = xbar_valid_i && xbar_allow_in_o;
  assign isu_valid_o      = xbar_valid_i && issue_ok;
  assign linefill_valid_o = xbar_valid_i && need_refill;
  assign bus_arvalid_o    = xbar_valid_i && need_refill && isu_allow_in_i;

  // --------------------
  // issue payload
  // --------------------
  assign isu_opcode_o      = isu_op_e'({evict_i, is_write});
  assign isu_ch_id_o       = xbar_ch_id_i;
  assign isu_wbuf_id_o     = xbar_wbuf_id_i;
  assign isu_set_o         = xbar_addr_i[TAG_LSB-1:LINE_LSB];
  assign isu_way_o         = way_i;
  assign isu_offset_o      = offset;
  assign isu_half0_state_o = half0_state_i;
  assign isu_half1_state_o = half1_state_i;

  assign bus_araddr_o = xbar_addr_i[ADDR_W-1:LINE_LSB];

endmodule

/* bank_htu_top.sv */
`timescale 1ns/1ps

module bank_htu_top
  import htu_geom_pkg::*, htu_op_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  // crossbar
  input  logic              xbar_valid_i,
  output logic              xbar_allow_in_o,
  input  logic [CH_W-1:0]   xbar_ch_id_i,
  input  xbar_op_e          xbar_opcode_i,
  input  req_addr_t         xbar_addr_i,
  input  logic [WBUF_W-1:0] xbar_wbuf_id_i,
  // issue unit
  output logic              isu_valid_o,
  input  logic              isu_allow_in_i,
  output logic [CH_W-1:0]   isu_ch_id_o,
  output isu_op_e           isu_opcode_o,
  output set_idx_t          isu_set_o,
  output way_idx_t          isu_way_o,
  output logic              isu_offset_o,
  output logic [WBUF_W-1:0] isu_wbuf_id_o,
  output half_state_e       isu_half0_state_o,
  output half_state_e       isu_half1_state_o,
  output logic              linefill_valid_o,
  // bus
  output logic              bus_arvalid_o,
  input  logic              bus_arready_i,
  output line_addr_t        bus_araddr_o
);

  logic        kickoff;
  logic        hit;
  logic        evict;
  way_idx_t    way;
  half_state_e half0_state;
  half_state_e half1_state;

  htu_tag_array u_tag_array (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .kickoff_i    (kickoff),
    .op_i         (xbar_opcode_i),
    .addr_i       (xbar_addr_i),
    .hit_o        (hit),
    .evict_o      (evict),
    .way_o        (way),
    .half0_state_o(half0_state),
    .half1_state_o(half1_state)
  );

  htu_dispatch u_dispatch (
    .xbar_valid_i     (xbar_valid_i),
    .xbar_allow_in_o  (xbar_allow_in_o),
    .xbar_opcode_i    (xbar_opcode_i),
    .xbar_addr_i      (xbar_addr_i),
    .xbar_ch_id_i     (xbar_ch_id_i),
    .xbar_wbuf_id_i   (xbar_wbuf_id_i),
    .hit_i            (hit),
    .evict_i          (evict),
    .way_i            (way),
    .half0_state_i    (half0_state),
    .half1_state_i    (half1_state),
    .kickoff_o        (kickoff),
    .isu_valid_o      (isu_valid_o),
    .isu_allow_in_i   (isu_allow_in_i),
    .isu_ch_id_o      (isu_ch_id_o),
    .isu_opcode_o     (isu_opcode_o),
    .isu_set_o        (isu_set_o),
    .isu_way_o        (isu_way_o),
    .isu_offset_o     (isu_offset_o),
    .isu_wbuf_id_o    (isu_wbuf_id_o),
    .isu_half0_state_o(isu_half0_state_o),
    .isu_half1_state_o(isu_half1_state_o),
    .linefill_valid_o (linefill_valid_o),
    .bus_arvalid_o    (bus_arvalid_o),
    .bus_arready_i    (bus_arready_i),
    .bus_araddr_o     (bus_araddr_o)
  );

endmodule

/* bank_htu_checker.sv */
`timescale 1ns/1ps

module bank_htu_checker (
  input logic clk_i,
  input logic rst_i,
  input logic xbar_allow_in_i,
  input logic isu_allow_in_i,
  input logic isu_valid_i,
  input logic linefill_valid_i,
  input logic bus_arvalid_i
);

  int fail_count = 0;

  // --------------------
  // handshake rules
  // --------------------
  allow_needs_isu: assert property (@(posedge clk_i) xbar_allow_in_i |-> isu_allow_in_i)
    else begin
      fail_count++;
      $error("crossbar accept while the issue unit is not ready");
    end

  bus_needs_fill: assert property (@(posedge clk_i) bus_arvalid_i |-> linefill_valid_i)
    else begin
      fail_count++;
      $error("bus read request without a line fill notice");
    end

  // quiet during reset
  reset_quiet: assert property (@(posedge clk_i)
      rst_i |-> !(isu_valid_i || linefill_valid_i || bus_arvalid_i))
    else begin
      fail_count++;
      $error("valid output high during reset");
    end

endmodule

bind bank_htu_top bank_htu_checker u_checker (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .xbar_allow_in_i (xbar_allow_in_o),
  .isu_allow_in_i  (isu_allow_in_i),
  .isu_valid_i     (isu_valid_o),
  .linefill_valid_i(linefill_valid_o),
  .bus_arvalid_i   (bus_arvalid_o)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

endmodule

/* bank_htu_tb.sv */
`timescale 1ns/1ps

module bank_htu_tb import htu_geom_pkg::*, htu_op_pkg::*;;

  localparam int CLK_NS       = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_REQUESTS = 19;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + 40 * NUM_REQUESTS) * CLK_NS;
  localparam set_idx_t SET_A  = 3'd2;

  logic              clk;
  logic              rst;
  logic              xbar_valid;
  logic              xbar_allow_in;
  logic [CH_W-1:0]   xbar_ch_id;
  xbar_op_e          xbar_opcode;
  req_addr_t         xbar_addr;
  logic [WBUF_W-1:0] xbar_wbuf_id;
  logic              isu_valid;
  logic              isu_allow_in;
  logic [CH_W-1:0]   isu_ch_id;
  isu_op_e           isu_opcode;
  set_idx_t          isu_set;
  way_idx_t          isu_way;
  logic              isu_offset;
  logic [WBUF_W-1:0] isu_wbuf_id;
  half_state_e       isu_half0_state;
  half_state_e       isu_half1_state;
  logic              linefill_valid;
  logic              bus_arvalid;
  logic              bus_arready;
  line_addr_t        bus_araddr;

  // reference tag model with halves indexed by offset
  tag_t        m_tag    [NUM_SETS][NUM_WAYS];
  logic        m_valid  [NUM_SETS][NUM_WAYS];
  half_state_e m_half   [NUM_SETS][NUM_WAYS][2];
  way_idx_t    m_victim [NUM_SETS];

  logic     e_hit;
  logic     e_evict;
  logic     e_refill;
  way_idx_t e_way;
  string    test_name;
  tag_t     tag_a;
  int       req_count;

  tb_clock_gen u_clk (.clk_o(clk));

  bank_htu_top uut (
    .clk_i(clk), .rst_i(rst),
    .xbar_valid_i(xbar_valid), .xbar_allow_in_o(xbar_allow_in),
    .xbar_ch_id_i(xbar_ch_id), .xbar_opcode_i(xbar_opcode),
    .xbar_addr_i(xbar_addr), .xbar_wbuf_id_i(xbar_wbuf_id),
    .isu_valid_o(isu_valid), .isu_allow_in_i(isu_allow_in),
    .isu_ch_id_o(isu_ch_id), .isu_opcode_o(isu_opcode),
    .isu_set_o(isu_set), .isu_way_o(isu_way), .isu_offset_o(isu_offset),
    .isu_wbuf_id_o(isu_wbuf_id), .isu_half0_state_o(isu_half0_state),
    .isu_half1_state_o(isu_half1_state), .linefill_valid_o(linefill_valid),
    .bus_arvalid_o(bus_arvalid), .bus_arready_i(bus_arready), .bus_araddr_o(bus_araddr)
  );

  // --------------------
  // compare tasks
  // --------------------
  task automatic fail_stop();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %0b, actual %0b", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic compare_isu_op(input string what, input isu_op_e exp, input isu_op_e act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %s, actual %s", test_name, what, exp.name(), act.name());
      fail_stop();
    end
  endtask

  task automatic compare_state(input string what, input half_state_e exp,
                               input half_state_e act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %s, actual %s", test_name, what, exp.name(), act.name());
      fail_stop();
    end
  endtask

  task automatic compare_way(input string what, input way_idx_t exp, input way_idx_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic compare_addr(input string what, input line_addr_t exp, input line_addr_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic compare_set(input string what, input set_idx_t exp, input set_idx_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic compare_ch_id(input string what, input logic [CH_W-1:0] exp,
                               input logic [CH_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic compare_wbuf_id(input string what, input logic [WBUF_W-1:0] exp,
                                 input logic [WBUF_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  function automatic req_addr_t make_addr(input tag_t t, input set_idx_t s, input logic off);
    return {t, s, off};
  endfunction

  task automatic predict(input xbar_op_e op, input req_addr_t addr);
    set_idx_t s;
    logic     dirty;
    s = addr[TAG_LSB-1:LINE_LSB];
    e_hit = 1'b0;
    e_way = m_victim[s];
    if (op != OP_RSVD) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == addr[ADDR_W-1:TAG_LSB]) begin
          e_hit = 1'b1;
          e_way = way_idx_t'(w);
        end
      end
    end
    dirty = (m_half[s][e_way][0] == HS_DIRTY) || (m_half[s][e_way][1] == HS_DIRTY);
    e_evict = dirty && ((!e_hit && (op == OP_READ || op == OP_WRITE))
                        || (e_hit && op == OP_INVALIDATE));
    e_refill = (op == OP_READ)
             && (!e_hit || m_half[s][e_way][addr[OFFSET_BIT]] == HS_EMPTY);
  endtask

  task automatic update_model(input xbar_op_e op, input req_addr_t addr);
    set_idx_t s;
    logic     off;
    s = addr[TAG_LSB-1:LINE_LSB];
    off = addr[OFFSET_BIT];
    if (e_hit) begin
      if (op == OP_READ && m_half[s][e_way][off] == HS_EMPTY) begin
        m_half[s][e_way][off] = HS_CLEAN;
      end else if (op == OP_WRITE) begin
        m_half[s][e_way][off] = HS_DIRTY;
      end else if (op == OP_INVALIDATE) begin
        m_valid[s][e_way] = 1'b0;
        m_half[s][e_way][0] = HS_EMPTY;
        m_half[s][e_way][1] = HS_EMPTY;
      end
    end else if (op == OP_READ || op == OP_WRITE) begin
      m_tag[s][e_way] = addr[ADDR_W-1:TAG_LSB];
      m_valid[s][e_way] = 1'b1;
      m_half[s][e_way][off] = (op == OP_WRITE) ? HS_DIRTY : HS_CLEAN;
      m_half[s][e_way][!off] = HS_EMPTY;
      m_victim[s] = way_idx_t'(m_victim[s] + 1'b1);
    end
  endtask

  task automatic check_outputs(input xbar_op_e op, input req_addr_t addr);
    set_idx_t s;
    logic     go;
    s = addr[TAG_LSB-1:LINE_LSB];
    go = !e_refill || bus_arready;
    compare_bit("xbar_allow_in", isu_allow_in && go, xbar_allow_in);
    compare_bit("isu_valid", go, isu_valid);
    compare_bit("linefill_valid", e_refill, linefill_valid);
    compare_bit("bus_arvalid", e_refill && isu_allow_in, bus_arvalid);
    // high bit evict and low bit write
    compare_isu_op("isu_opcode", isu_op_e'({e_evict, op == OP_WRITE}), isu_opcode);
    compare_way("isu_way", e_way, isu_way);
    compare_state("isu_half0_state", m_half[s][e_way][0], isu_half0_state);
    compare_state("isu_half1_state", m_half[s][e_way][1], isu_half1_state);
    compare_bit("isu_offset", addr[OFFSET_BIT], isu_offset);
    compare_set("isu_set", s, isu_set);
    compare_ch_id("isu_ch_id", xbar_ch_id, isu_ch_id);
    compare_wbuf_id("isu_wbuf_id", xbar_wbuf_id, isu_wbuf_id);
    compare_addr("bus_araddr", addr[ADDR_W-1:LINE_LSB], bus_araddr);
  endtask

  // stalls set by the caller last for hold cycles before both sides go ready
  task automatic send_request(input xbar_op_e op, input req_addr_t addr, input int hold);
    predict(op, addr);
    @(posedge clk);
    #1;
    xbar_valid = 1'b1;
    xbar_opcode = op;
    xbar_addr = addr;
    xbar_ch_id = CH_W'($urandom);
    xbar_wbuf_id = WBUF_W'(req_count);
    repeat (hold) begin
      #1;
      check_outputs(op, addr);
      @(posedge clk);
      #1;
    end
    isu_allow_in = 1'b1;
    bus_arready = 1'b1;
    #1;
    check_outputs(op, addr);
    while (xbar_allow_in !== 1'b1) @(posedge clk);
    @(posedge clk);
    update_model(op, addr);
    req_count++;
    #1;
    xbar_valid = 1'b0;
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_reads();
    test_name = "cold_read";
    tag_a = tag_t'($urandom);
    send_request(OP_READ, make_addr(tag_a, SET_A, 1'b0), 0);
    test_name = "warm_read";
    send_request(OP_READ, make_addr(tag_a, SET_A, 1'b0), 0);
    send_request(OP_READ, make_addr(tag_a, SET_A, 1'b1), 0);
  endtask

  task automatic test_writes();
    tag_t base;
    test_name = "write_hit";
    send_request(OP_WRITE, make_addr(tag_a, SET_A, 1'b0), 0);
    // nine misses to one set wrap onto dirty way 0
    test_name = "write_fill";
    base = tag_t'($urandom);
    for (int i = 0; i < NUM_WAYS + 1; i++) begin
      send_request(OP_WRITE, make_addr(tag_t'(base + i), 3'd5, i[0]), 0);
    end
  endtask

  task automatic test_invalidate();
    test_name = "invalidate";
    send_request(OP_INVALIDATE, make_addr(tag_a, SET_A, 1'b0), 0);
    send_request(OP_READ, make_addr(tag_a, SET_A, 1'b0), 0);
  endtask

  task automatic test_backpressure();
    test_name = "isu_stall";
    isu_allow_in = 1'b0;
    send_request(OP_WRITE, make_addr(tag_a, SET_A, 1'b0), 3);
    send_request(OP_READ, make_addr(tag_a, SET_A, 1'b0), 0);
    test_name = "bus_stall";
    bus_arready = 1'b0;
    send_request(OP_READ, make_addr(tag_t'($urandom), 3'd7, 1'b1), 3);
    send_request(OP_READ, make_addr(tag_a, SET_A, 1'b1), 0);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    fail_stop();
  end

  // first handshake assertion failure ends the run
  initial begin
    wait (uut.u_checker.fail_count != 0);
    $display("Handshake checker reported an assertion failure");
    fail_stop();
  end

  initial begin
    void'($urandom(32'h69f7));
    rst = 1'b1;
    xbar_valid = 1'b0;
    xbar_ch_id = '0;
    xbar_opcode = OP_READ;
    xbar_addr = '0;
    xbar_wbuf_id = '0;
    isu_allow_in = 1'b1;
    bus_arready = 1'b1;
    req_count = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_victim[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w] = '0;
        m_valid[s][w] = 1'b0;
        m_half[s][w][0] = HS_EMPTY;
        m_half[s][w][1] = HS_EMPTY;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    test_name = "idle";
    #1;
    compare_bit("isu_valid", 1'b0, isu_valid);
    compare_bit("linefill_valid", 1'b0, linefill_valid);
    compare_bit("bus_arvalid", 1'b0, bus_arvalid);
    test_reads();
    test_writes();
    test_invalidate();
    test_backpressure();
    repeat (2) @(posedge clk);
    #1;
    if (uut.u_checker.fail_count != 0) begin
      $display("Handshake checker reported %0d assertion failures", uut.u_checker.fail_count);
      fail_stop();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* compile.f */
htu_geom_pkg.sv
htu_op_pkg.sv
htu_set_entry.sv
htu_tag_array.sv
htu_dispatch.sv
bank_htu_top.sv
bank_htu_checker.sv
tb_clock_gen.sv
bank_htu_tb.sv
